//--- build.f
logic/trap_pkg.sv
logic/exception_prioritizer.sv
logic/interrupt_controller.sv
logic/trap_csr_file.sv
logic/pc_redirect.sv
logic/trap_unit.sv
dv/trap_unit_tb.sv

//--- dv/trap_unit_tb.sv
`timescale 1ns/1ns

module trap_unit_tb;

    import trap_pkg::*;

    localparam word       RESET_ADDR   = 32'h0000_1000;
    localparam word       INST_WORD    = 32'h0ff0_0113;
    localparam word       DATA_ADDR    = 32'h0000_2003;
    localparam int        RESET_CYCLES = 8;
    localparam csr_addr_e CSR_UNKNOWN  = csr_addr_e'(12'h300);

    // One cycle of stimulus and the outputs expected in it
    typedef struct packed {
        word           pc;
        word           npc;
        exc_flags_t    exc;
        logic [4:0]    ctl;     // mtime, global_mie, machine, mret, dbus_wait
        platform_irq_t plat;
        logic [1:0]    op;      // rd_en, wr_en
        csr_addr_e     addr;
        word           wdata;
        word           exp_pc;
        logic [1:0]    exp_te;  // trap, exception
        word           exp_rd;
    } row_t;

    logic          clk;
    logic          rst_n;
    word           pc;
    word           decoder_next_pc;
    exc_flags_t    exc;
    word           inst;
    word           data_addr;
    logic          mtime_irq;
    platform_irq_t plat_irq;
    logic          global_mie;
    priv_mode_e    priv;
    csr_req_t      csr;
    logic          mret;
    logic          dbus_wait;
    word           next_pc;
    word           csr_rd_data;
    logic          trap;
    logic          exception;

    row_t rows[$];
    int   row_idx;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    trap_unit #(
        .RESET_ADDR (RESET_ADDR)
    ) i_trap_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .decoder_next_pc (decoder_next_pc),
        .next_pc         (next_pc),
        .exc             (exc),
        .inst            (inst),
        .data_addr       (data_addr),
        .mtime_irq       (mtime_irq),
        .plat_irq        (plat_irq),
        .global_mie      (global_mie),
        .priv            (priv),
        .csr             (csr),
        .csr_rd_data     (csr_rd_data),
        .mret            (mret),
        .dbus_wait       (dbus_wait),
        .trap            (trap),
        .exception       (exception)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic compare(input string what, input word got, input word expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: row %0d, %s is %h, expected %h",
                     $time, row_idx, what, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic add_row(
        input word           pc_in,
        input word           npc_in,
        input exc_flags_t    exc_in,
        input logic [4:0]    ctl_in,
        input platform_irq_t plat_in,
        input logic [1:0]    op_in,
        input csr_addr_e     addr_in,
        input word           wdata_in,
        input word           exp_pc_in,
        input logic [1:0]    exp_te_in,
        input word           exp_rd_in
    );
        row_t r;
        r = '{pc_in, npc_in, exc_in, ctl_in, plat_in, op_in, addr_in, wdata_in,
              exp_pc_in, exp_te_in, exp_rd_in};
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        pc              = r.pc;
        decoder_next_pc = r.npc;
        exc             = r.exc;
        mtime_irq       = r.ctl[4];
        global_mie      = r.ctl[3];
        priv            = r.ctl[2] ? PRIV_MACHINE : PRIV_USER;
        mret            = r.ctl[1];
        dbus_wait       = r.ctl[0];
        plat_irq        = r.plat;
        csr = '{rd_en: r.op[1], wr_en: r.op[0], addr: r.addr, wr_data: r.wdata};
    endtask

    task automatic check_row(input row_t r);
        compare("next_pc", next_pc, r.exp_pc);
        compare("trap", {31'b0, trap}, {31'b0, r.exp_te[1]});
        compare("exception", {31'b0, exception}, {31'b0, r.exp_te[0]});
        compare("csr_rd_data", csr_rd_data, r.exp_rd);
    endtask

    task automatic check_reset();
        compare("next_pc", next_pc, RESET_ADDR);
        compare("trap", {31'b0, trap}, 32'h0);
        compare("exception", {31'b0, exception}, 32'h0);
        compare("csr_rd_data", csr_rd_data, 32'h0);
    endtask

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    // pc, decoder_next_pc, exc, ctl, plat, op, addr, wdata, next_pc, trap/exc, rd_data
    task automatic build_table();
        // Boot, every CSR reads zero
        add_row('h200, 'h204, 'h000, 'b00100, 'h000, 'b10, CSR_MTVEC, 'h0, RESET_ADDR, 'b00, 'h0);
        add_row('h210, 'h214, 'h000, 'b00100, 'h000, 'b10, CSR_MIP, 'h0, 'h214, 'b00, 'h0);
        add_row('h220, 'h224, 'h000, 'b00100, 'h000, 'b10, CSR_MIE, 'h0, 'h224, 'b00, 'h0);
        add_row('h230, 'h234, 'h000, 'b00100, 'h000, 'b10, CSR_MEPC, 'h0, 'h234, 'b00, 'h0);
        add_row('h240, 'h244, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h244, 'b00, 'h0);
        add_row('h250, 'h254, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h254, 'b00, 'h0);
        // Write masks and read mux
        add_row('h260, 'h264, 'h000, 'b00100, 'h000, 'b01, CSR_MTVEC, 'h4000, 'h264, 'b00, 'h0);
        add_row('h270, 'h274, 'h000, 'b00100, 'h000, 'b10, CSR_MTVEC, 'h0, 'h274, 'b00, 'h4000);
        add_row('h280, 'h284, 'h000, 'b00100, 'h000, 'b01, CSR_MEPC, 'h3337, 'h284, 'b00, 'h0);
        add_row('h290, 'h294, 'h000, 'b00100, 'h000, 'b10, CSR_MEPC, 'h0, 'h294, 'b00, 'h3334);
        add_row('h2a0, 'h2a4, 'h000, 'b00100, 'h000, 'b01, CSR_MIE, 'hffffffff, 'h2a4, 'b00, 'h0);
        add_row('h2b0, 'h2b4, 'h000, 'b00100, 'h000, 'b10, CSR_MIE, 'h0, 'h2b4, 'b00, 'hffff0080);
        add_row('h2c0, 'h2c4, 'h000, 'b00100, 'h000, 'b01, CSR_MIE, 'h0, 'h2c4, 'b00, 'h0);
        add_row('h2d0, 'h2d4, 'h000, 'b00100, 'h000, 'b01, CSR_MCAUSE, 'h80000013, 'h2d4, 'b00, 'h0);
        add_row('h2e0, 'h2e4, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h2e4, 'b00, 'h80000013);
        add_row('h2f0, 'h2f4, 'h000, 'b00100, 'h000, 'b01, CSR_MTVAL, 'hcafef00d, 'h2f4, 'b00, 'h0);
        add_row('h300, 'h304, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h304, 'b00, 'hcafef00d);
        add_row('h310, 'h314, 'h000, 'b00100, 'h000, 'b10, CSR_UNKNOWN, 'h0, 'h314, 'b00, 'h0);
        // Exception priority with direct base 0x4000
        add_row('h400, 'h404, 'h150, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h410, 'h414, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h414, 'b00, 'h1);
        add_row('h420, 'h424, 'h000, 'b00100, 'h000, 'b10, CSR_MEPC, 'h0, 'h424, 'b00, 'h400);
        add_row('h430, 'h434, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h434, 'b00, 'h400);
        add_row('h440, 'h446, 'h08c, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h4000, 'b11, 'h1);
        add_row('h450, 'h454, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h454, 'b00, 'h446);
        add_row('h460, 'h464, 'h000, 'b00100, 'h000, 'b10, CSR_MEPC, 'h0, 'h464, 'b00, 'h440);
        add_row('h468, 'h46c, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h46c, 'b00, 'h0);
        add_row('h470, 'h474, 'h033, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h480, 'h484, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h484, 'b00, 'h0ff00113);
        add_row('h488, 'h48c, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h48c, 'b00, 'h2);
        add_row('h490, 'h494, 'h018, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h4a0, 'h4a4, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h4a4, 'b00, 'hb);
        add_row('h4b0, 'h4b4, 'h010, 'b00000, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h4c0, 'h4c4, 'h000, 'b00000, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h4c4, 'b00, 'h8);
        add_row('h4d0, 'h4d4, 'h006, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h4e0, 'h4e4, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h4e4, 'b00, 'h6);
        add_row('h4f0, 'h4f4, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h4f4, 'b00, 'h2003);
        add_row('h500, 'h504, 'h003, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h4000, 'b11, 'h0);
        add_row('h510, 'h514, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h514, 'b00, 'h5);
        // Interrupt pending, enables and selection
        add_row('h600, 'h604, 'h000, 'b00000, 'h002, 'b00, CSR_MTVEC, 'h0, 'h604, 'b00, 'h0);
        add_row('h610, 'h614, 'h000, 'b00000, 'h000, 'b10, CSR_MIP, 'h0, 'h614, 'b00, 'h20000);
        add_row('h620, 'h624, 'h000, 'b00100, 'h010, 'b01, CSR_MIE, 'h120000, 'h624, 'b00, 'h0);
        add_row('h630, 'h634, 'h000, 'b00100, 'h000, 'b10, CSR_MIP, 'h0, 'h634, 'b00, 'h120000);
        add_row('h640, 'h644, 'h000, 'b01100, 'h000, 'b10, CSR_MIE, 'h0, 'h4000, 'b10, 'h120000);
        add_row('h650, 'h654, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h654, 'b00, 'h80000011);
        add_row('h660, 'h664, 'h000, 'b00100, 'h000, 'b10, CSR_MEPC, 'h0, 'h664, 'b00, 'h644);
        add_row('h670, 'h674, 'h000, 'b00100, 'h000, 'b10, CSR_MTVAL, 'h0, 'h674, 'b00, 'h0);
        add_row('h680, 'h684, 'h000, 'b00100, 'h000, 'b01, CSR_MIP, 'h0, 'h684, 'b00, 'h0);
        add_row('h690, 'h694, 'h000, 'b11100, 'h000, 'b10, CSR_MIP, 'h0, 'h694, 'b00, 'h80);
        // Vectored base 0x6000
        add_row('h700, 'h704, 'h000, 'b00100, 'h000, 'b01, CSR_MTVEC, 'h6041, 'h704, 'b00, 'h0);
        add_row('h710, 'h714, 'h000, 'b00100, 'h010, 'b00, CSR_MTVEC, 'h0, 'h714, 'b00, 'h0);
        add_row('h720, 'h724, 'h000, 'b01100, 'h000, 'b10, CSR_MTVEC, 'h0, 'h6050, 'b10, 'h6041);
        add_row('h730, 'h734, 'h008, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h6000, 'b11, 'h0);
        add_row('h738, 'h73c, 'h000, 'b00100, 'h000, 'b10, CSR_MCAUSE, 'h0, 'h73c, 'b00, 'h3);
        add_row('h740, 'h744, 'h000, 'b00100, 'h000, 'b11, CSR_MIP, 'h0, 'h744, 'b00, 'h100000);
        // Return and stall
        add_row('h750, 'h754, 'h000, 'b00110, 'h000, 'b00, CSR_MTVEC, 'h0, 'h730, 'b00, 'h0);
        add_row('h760, 'h764, 'h000, 'b00111, 'h000, 'b00, CSR_MTVEC, 'h0, 'h760, 'b00, 'h0);
        add_row('h770, 'h774, 'h040, 'b00101, 'h000, 'b00, CSR_MTVEC, 'h0, 'h770, 'b11, 'h0);
        add_row('h780, 'h784, 'h000, 'b00110, 'h000, 'b10, CSR_MEPC, 'h0, 'h770, 'b00, 'h770);
        add_row('h790, 'h794, 'h000, 'b00100, 'h000, 'b00, CSR_MTVEC, 'h0, 'h794, 'b00, 'h0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        pc              = '0;
        decoder_next_pc = '0;
        exc             = '0;
        inst            = INST_WORD;
        data_addr       = DATA_ADDR;
        mtime_irq       = 1'b0;
        plat_irq        = '0;
        global_mie      = 1'b0;
        priv            = PRIV_MACHINE;
        csr             = '{rd_en: 1'b1, wr_en: 1'b0, addr: CSR_MTVEC, wr_data: '0};
        mret            = 1'b0;
        dbus_wait       = 1'b0;
        row_idx         = -1;

        build_table();
        cycle_limit = rows.size() + RESET_CYCLES + 20;

        // Outputs held at their reset values once the first edge has passed
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            #95;
            check_reset();
        end
        @(posedge clk);
        #5;
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            row_idx = i;
            drive_row(rows[i]);
            #90;
            check_row(rows[i]);
            @(posedge clk);
            #5;
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- logic/exception_prioritizer.sv
`timescale 1ns/1ns

module exception_prioritizer (
    input  trap_pkg::exc_flags_t exc,
    input  trap_pkg::priv_mode_e priv,
    input  trap_pkg::word        pc,
    input  trap_pkg::word        decoder_next_pc,
    input  trap_pkg::word        inst,
    input  trap_pkg::word        data_addr,
    input  logic                 irq_valid,
    input  trap_pkg::trap_code_e irq_code,
    output trap_pkg::trap_info_t info
);

    import trap_pkg::*;

    ////////////////////////////////////////
    // Fixed exception priority
    ////////////////////////////////////////

    always_comb begin
        info.exception = 1'b1;
        info.tval      = '0;

        if (exc.inst_access_fault) begin
            info.code = TRAP_INST_ACCESS_FAULT;
            info.tval = pc;
        end else if (exc.inst_misaligned) begin
            // Faulting target is the one the decoder produced
            info.code = TRAP_INST_MISALIGNED;
            info.tval = decoder_next_pc;
        end else if (exc.illegal_inst || exc.illegal_csr) begin
            info.code = TRAP_ILLEGAL_INST;
            info.tval = inst;
        end else if (exc.ecall) begin
            info.code = (priv == PRIV_MACHINE) ? TRAP_ECALL_M : TRAP_ECALL_U;
        end else if (exc.ebreak) begin
            info.code = TRAP_BREAKPOINT;
        end else if (exc.data_misaligned) begin
            info.code = exc.load_store_n ? TRAP_LOAD_MISALIGNED
                                         : TRAP_STORE_MISALIGNED;
            info.tval = data_addr;
        end else if (exc.data_access_fault) begin
            info.code = exc.load_store_n ? TRAP_LOAD_ACCESS_FAULT
                                         : TRAP_STORE_ACCESS_FAULT;
            info.tval = data_addr;
        end else begin
            // No exception, fall back to the pending interrupt
            info.exception = 1'b0;
            info.code      = irq_code;
        end

        info.trap = info.exception || irq_valid;

        // Interrupt codes all fit the vector table
        info.vector_ok = !info.exception;

        // Exceptions retry the faulting pc, interrupts resume at the next one
        if (info.exception) begin
            info.epc = {pc[xlen-1:2], 2'b00};
        end else begin
            info.epc = {decoder_next_pc[xlen-1:2], 2'b00};
        end
    end

endmodule

//--- logic/interrupt_controller.sv
`timescale 1ns/1ns

module interrupt_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mtime_irq,
    input  trap_pkg::platform_irq_t plat_irq,
    input  trap_pkg::csr_req_t      csr,
    input  trap_pkg::priv_mode_e    priv,
    input  logic                    global_mie,
    output logic                    irq_valid,
    output trap_pkg::trap_code_e    irq_code,
    output trap_pkg::word           mip_value,
    output trap_pkg::word           mie_value
);

    import trap_pkg::*;

    // Platform pending bits live in mip[31:16]
    logic [15:0] mip_hi;
    logic [15:0] mip_hi_next;
    logic [15:0] mie_hi;
    logic        mie_mtie;
    logic        irq_enable;
    word         pending;

    ////////////////////////////////////////
    // Pending and enable registers
    ////////////////////////////////////////

    // A pulse sets its bit even when software writes mip in the same cycle
    always_comb begin
        mip_hi_next = mip_hi;
        if (csr.wr_en && csr.addr == CSR_MIP) begin
            mip_hi_next = csr.wr_data[31:16];
        end
        mip_hi_next = mip_hi_next | {6'b0, plat_irq};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mip_hi   <= '0;
            mie_hi   <= '0;
            mie_mtie <= 1'b0;
        end else begin
            mip_hi <= mip_hi_next;
            if (csr.wr_en && csr.addr == CSR_MIE) begin
                mie_hi   <= csr.wr_data[31:16];
                mie_mtie <= csr.wr_data[IRQ_MTIME];
            end
        end
    end

    // Only the timer bit and the platform bits exist
    always_comb begin
        mip_value            = '0;
        mip_value[31:16]     = mip_hi;
        mip_value[IRQ_MTIME] = mtime_irq;

        mie_value            = '0;
        mie_value[31:16]     = mie_hi;
        mie_value[IRQ_MTIME] = mie_mtie;
    end

    ////////////////////////////////////////
    // Masking and selection
    ////////////////////////////////////////

    // User mode can always be interrupted
    assign irq_enable = (priv == PRIV_MACHINE) ? global_mie : 1'b1;
    assign pending    = irq_enable ? (mip_value & mie_value) : '0;
    assign irq_valid  = |pending;

    // Scan downward so the lowest index is left standing
    always_comb begin
        irq_code = trap_code_e'(5'd0);
        for (int i = xlen - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_code = trap_code_e'(5'(i));
            end
        end
    end

endmodule

//--- logic/pc_redirect.sv
`timescale 1ns/1ns

module pc_redirect #(
    parameter trap_pkg::word RESET_ADDR = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::word        pc,
    input  trap_pkg::word        decoder_next_pc,
    input  trap_pkg::trap_info_t info,
    input  trap_pkg::word        mtvec_value,
    input  trap_pkg::word        mepc_value,
    input  logic                 mret,
    input  logic                 dbus_wait,
    output trap_pkg::word        next_pc
);

    import trap_pkg::*;

    logic        first_cycle;
    mtvec_mode_e mode;
    word         base_direct;
    word         base_vectored;
    word         trap_target;

    // High from reset until the first cycle after it has passed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Trap targets
    ////////////////////////////////////////

    assign mode          = mtvec_mode_e'(mtvec_value[1:0]);
    assign base_direct   = {mtvec_value[xlen-1:2], 2'b00};
    assign base_vectored = {mtvec_value[xlen-1:7], 7'b0};

    // Reserved modes behave as direct
    always_comb begin
        if (mode == MTVEC_VECTORED) begin
            trap_target = base_vectored;
            if (info.vector_ok) begin
                trap_target = base_vectored + {25'b0, info.code, 2'b00};
            end
        end else begin
            trap_target = base_direct;
        end
    end

    ////////////////////////////////////////
    // Next pc select
    ////////////////////////////////////////

    always_comb begin
        if (first_cycle) begin
            next_pc = RESET_ADDR;
        end else if (dbus_wait) begin
            next_pc = pc;
        end else if (info.trap) begin
            next_pc = trap_target;
        end else if (mret) begin
            next_pc = mepc_value;
        end else begin
            next_pc = decoder_next_pc;
        end
    end

endmodule

//--- logic/trap_csr_file.sv
`timescale 1ns/1ns

module trap_csr_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trap_pkg::csr_req_t   csr,
    input  trap_pkg::trap_info_t info,
    input  trap_pkg::word        mip_value,
    input  trap_pkg::word        mie_value,
    output trap_pkg::word        mtvec_value,
    output trap_pkg::word        mepc_value,
    output trap_pkg::word        csr_rd_data
);

    import trap_pkg::*;

    word         mtvec;
    logic [29:0] mepc_hi;
    word         mcause;
    word         mtval;
    logic        wr_mtvec;
    logic        wr_mepc;
    logic        wr_mcause;
    logic        wr_mtval;

    ////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////

    assign wr_mtvec  = csr.wr_en && (csr.addr == CSR_MTVEC);
    assign wr_mepc   = csr.wr_en && (csr.addr == CSR_MEPC);
    assign wr_mcause = csr.wr_en && (csr.addr == CSR_MCAUSE);
    assign wr_mtval  = csr.wr_en && (csr.addr == CSR_MTVAL);

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (wr_mtvec) begin
            mtvec <= csr.wr_data;
        end
    end

    // Trap capture wins over a software write in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc_hi <= '0;
            mcause  <= '0;
            mtval   <= '0;
        end else if (info.trap) begin
            mepc_hi <= info.epc[xlen-1:2];
            // Interrupt flag on top, code in the low bits
            mcause  <= {~info.exception, 26'b0, info.code};
            mtval   <= info.tval;
        end else begin
            if (wr_mepc) begin
                mepc_hi <= csr.wr_data[xlen-1:2];
            end
            if (wr_mcause) begin
                mcause <= csr.wr_data;
            end
            if (wr_mtval) begin
                mtval <= csr.wr_data;
            end
        end
    end

    // mepc is always word aligned
    assign mepc_value  = {mepc_hi, 2'b00};
    assign mtvec_value = mtvec;

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        csr_rd_data = '0;
        if (csr.rd_en) begin
            case (csr.addr)
                CSR_MTVEC:  csr_rd_data = mtvec;
                CSR_MIP:    csr_rd_data = mip_value;
                CSR_MIE:    csr_rd_data = mie_value;
                CSR_MEPC:   csr_rd_data = mepc_value;
                CSR_MCAUSE: csr_rd_data = mcause;
                CSR_MTVAL:  csr_rd_data = mtval;
                default:    csr_rd_data = '0;
            endcase
        end
    end

endmodule

//--- logic/trap_pkg.sv
package trap_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word;

    ////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    // Machine-mode trap CSR numbers
    typedef enum logic [11:0] {
        CSR_MIE    = 12'h304,
        CSR_MTVEC  = 12'h305,
        CSR_MEPC   = 12'h341,
        CSR_MCAUSE = 12'h342,
        CSR_MTVAL  = 12'h343,
        CSR_MIP    = 12'h344
    } csr_addr_e;

    typedef enum logic [4:0] {
        TRAP_INST_MISALIGNED    = 5'd0,
        TRAP_INST_ACCESS_FAULT  = 5'd1,
        TRAP_ILLEGAL_INST       = 5'd2,
        TRAP_BREAKPOINT         = 5'd3,
        TRAP_LOAD_MISALIGNED    = 5'd4,
        TRAP_LOAD_ACCESS_FAULT  = 5'd5,
        TRAP_STORE_MISALIGNED   = 5'd6,
        TRAP_STORE_ACCESS_FAULT = 5'd7,
        TRAP_ECALL_U            = 5'd8,
        TRAP_ECALL_M            = 5'd11,
        // Platform interrupt lines
        IRQ_UART_RX             = 5'd16,
        IRQ_UART_TX             = 5'd17,
        IRQ_TIMER0              = 5'd18,
        IRQ_TIMER1              = 5'd19,
        IRQ_GPIO_A0             = 5'd20,
        IRQ_GPIO_A1             = 5'd21,
        IRQ_GPIO_B0             = 5'd22,
        IRQ_GPIO_B1             = 5'd23,
        IRQ_GPIO_C0             = 5'd24,
        IRQ_GPIO_C1             = 5'd25
    } trap_code_e;

    // Machine timer shares code 7 with store access fault
    localparam trap_code_e IRQ_MTIME = trap_code_e'(5'd7);

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_e;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic inst_access_fault;
        logic inst_misaligned;
        logic illegal_inst;
        logic illegal_csr;
        logic ecall;
        logic ebreak;
        logic data_misaligned;
        logic data_access_fault;
        logic load_store_n;     // 1 for a load
    } exc_flags_t;

    // Bit n carries the pulse for code 16 + n
    typedef struct packed {
        logic gpio_c1;
        logic gpio_c0;
        logic gpio_b1;
        logic gpio_b0;
        logic gpio_a1;
        logic gpio_a0;
        logic timer1;
        logic timer0;
        logic uart_tx;
        logic uart_rx;
    } platform_irq_t;

    typedef struct packed {
        logic      rd_en;
        logic      wr_en;
        csr_addr_e addr;
        word       wr_data;
    } csr_req_t;

    typedef struct packed {
        logic       trap;
        logic       exception;
        trap_code_e code;
        logic       vector_ok;
        word        tval;
        word        epc;
    } trap_info_t;

endpackage

//--- logic/trap_unit.sv
`timescale 1ns/1ns

module trap_unit #(
    parameter trap_pkg::word RESET_ADDR = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Program counter
    input  trap_pkg::word           pc,
    input  trap_pkg::word           decoder_next_pc,
    output trap_pkg::word           next_pc,

    // Exception sources and their metadata
    input  trap_pkg::exc_flags_t    exc,
    input  trap_pkg::word           inst,
    input  trap_pkg::word           data_addr,

    // Interrupt lines
    input  logic                    mtime_irq,
    input  trap_pkg::platform_irq_t plat_irq,
    input  logic                    global_mie,
    input  trap_pkg::priv_mode_e    priv,

    // CSR access
    input  trap_pkg::csr_req_t      csr,
    output trap_pkg::word           csr_rd_data,

    input  logic                    mret,
    input  logic                    dbus_wait,
    output logic                    trap,
    output logic                    exception
);

    import trap_pkg::*;

    logic       irq_valid;
    trap_code_e irq_code;
    word        mip_value;
    word        mie_value;
    trap_info_t info;
    word        mtvec_value;
    word        mepc_value;

    interrupt_controller i_interrupt_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .mtime_irq  (mtime_irq),
        .plat_irq   (plat_irq),
        .csr        (csr),
        .priv       (priv),
        .global_mie (global_mie),
        .irq_valid  (irq_valid),
        .irq_code   (irq_code),
        .mip_value  (mip_value),
        .mie_value  (mie_value)
    );

    exception_prioritizer i_exception_prioritizer (
        .exc             (exc),
        .priv            (priv),
        .pc              (pc),
        .decoder_next_pc (decoder_next_pc),
        .inst            (inst),
        .data_addr       (data_addr),
        .irq_valid       (irq_valid),
        .irq_code        (irq_code),
        .info            (info)
    );

    trap_csr_file i_trap_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr         (csr),
        .info        (info),
        .mip_value   (mip_value),
        .mie_value   (mie_value),
        .mtvec_value (mtvec_value),
        .mepc_value  (mepc_value),
        .csr_rd_data (csr_rd_data)
    );

    pc_redirect #(
        .RESET_ADDR (RESET_ADDR)
    ) i_pc_redirect (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .decoder_next_pc (decoder_next_pc),
        .info            (info),
        .mtvec_value     (mtvec_value),
        .mepc_value      (mepc_value),
        .mret            (mret),
        .dbus_wait       (dbus_wait),
        .next_pc         (next_pc)
    );

    assign trap      = info.trap;
    assign exception = info.exception;

endmodule
